//--- verilog.f
verilog/io_pkg.sv
verilog/input_sync.sv
verilog/debounce.sv
verilog/ms_timer.sv
verilog/io_regs.sv
verilog/io_system.sv
dv/io_system_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP := io_system_tb
FILELIST := verilog.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS := --binary --timing --assert -Wno-fatal -Mdir obj_dir
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Pass or fail comes from the log, not the exit status
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- dv/io_system_tb.sv
`timescale 1ns/1ps

// Testbench for the I/O block
// Bus tasks drive requests and concurrent assertions compare against a small model
module io_system_tb;

	// Register addresses inside the window
	localparam logic [31:0] LED_ADDR = io_pkg::IO_BASE | 32'(io_pkg::LED_OFFSET);
	localparam logic [31:0] SW_ADDR = io_pkg::IO_BASE | 32'(io_pkg::SW_OFFSET);
	localparam logic [31:0] BTN_ADDR = io_pkg::IO_BASE | 32'(io_pkg::BTN_OFFSET);
	localparam logic [31:0] TIMER_ADDR = io_pkg::IO_BASE | 32'(io_pkg::TIMER_OFFSET);
	// Hole in the map and an address outside the window
	localparam logic [31:0] HOLE_ADDR = io_pkg::IO_BASE | 32'h0000_0008;
	localparam logic [31:0] STRAY_ADDR = 32'h0000_9000;

	localparam int ACK_LIMIT = 8;
	// Whole sequence runs well under a thousand cycles
	localparam int MAX_CYCLES = 5000;
	localparam int HOLD_CYCLES = io_pkg::DEBOUNCE_CYCLES + 4;
	localparam int GLITCH_CYCLES = io_pkg::DEBOUNCE_CYCLES - 3;

	logic clk;
	logic rst;
	io_pkg::wb_req_t wb_req;
	io_pkg::wb_rsp_t wb_rsp;
	io_pkg::sw_t sw_pins;
	io_pkg::btn_t btn_pins;
	io_pkg::sw_t led;

	// Model state
	io_pkg::sw_t exp_led;
	io_pkg::btn_t exp_btn;
	logic [31:0] timer_v;
	int timer_cycle;
	logic [31:0] exp_rd;
	logic rd_check;

	int cycle;
	int ack_cycle;
	int mismatches;
	int other_errors;

	io_system dut0 (
		.clk(clk),
		.rst(rst),
		.wb_req_i(wb_req),
		.wb_rsp_o(wb_rsp),
		.sw_i(sw_pins),
		.btn_i(btn_pins),
		.led_o(led)
	);

	// 20 ns clock
	always #10 clk = ~clk;

	// Cycle count that also bounds the run
	always @(posedge clk) begin
		cycle = cycle + 1;
		if (cycle >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles, the sequence never finished", cycle);
			$display("test failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Model helpers
	//////////////////////////////////////////////////

	function automatic logic addr_in_window(input logic [31:0] addr);
		return addr[31:io_pkg::IO_ADDR_BITS] == io_pkg::IO_BASE[31:io_pkg::IO_ADDR_BITS];
	endfunction

	// Read value as seen at the ack edge
	function automatic logic [31:0] expected_read(input logic [31:0] addr);
		logic [31:0] value;
		case (addr[7:0])
			io_pkg::LED_OFFSET: value = 32'(exp_led);
			io_pkg::SW_OFFSET: value = 32'(sw_pins);
			io_pkg::BTN_OFFSET: value = {27'd0, exp_btn.u, exp_btn.r, exp_btn.d, exp_btn.l,
				exp_btn.c};
			// Count as it stood just before the read edge
			io_pkg::TIMER_OFFSET: value = timer_v +
				32'((ack_cycle - timer_cycle - 1) / io_pkg::CLOCKS_PER_MS);
			default: value = 32'd0;
		endcase
		return value;
	endfunction

	task automatic note_write(input logic [31:0] addr, input logic [31:0] data);
		if (addr[7:0] == io_pkg::LED_OFFSET) begin
			exp_led = data[io_pkg::LED_WIDTH-1:0];
		end else if (addr[7:0] == io_pkg::TIMER_OFFSET) begin
			timer_v = data;
			timer_cycle = ack_cycle;
		end
	endtask

	task automatic report_mismatch(input string msg);
		mismatches = mismatches + 1;
		$display("Mismatch at %0t: %s", $time, msg);
	endtask

	//////////////////////////////////////////////////
	// Bus tasks
	//////////////////////////////////////////////////

	// One classic cycle held until ack
	task automatic bus_cycle(input logic we, input logic [31:0] addr, input logic [31:0] data);
		int waited;
		waited = 0;
		@(posedge clk);
		#2;
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we = we;
		wb_req.adr = addr;
		wb_req.dat = data;
		// Ack looked at just after each edge
		while (waited < ACK_LIMIT && !wb_rsp.ack) begin
			@(posedge clk);
			#1;
			waited = waited + 1;
		end
		if (!wb_rsp.ack) begin
			other_errors = other_errors + 1;
			$display("No ack for access to 0x%08h within %0d cycles (time %0t)",
				addr, ACK_LIMIT, $time);
		end else begin
			ack_cycle = cycle;
			if (we) begin
				note_write(addr, data);
			end else begin
				exp_rd = expected_read(addr);
				rd_check = 1'b1;
			end
		end
		#1;
		wb_req.cyc = 1'b0;
		wb_req.stb = 1'b0;
		wb_req.we = 1'b0;
		// Read check stays armed through the ack cycle
		@(posedge clk);
		#2;
		rd_check = 1'b0;
	endtask

	task automatic wb_write(input logic [31:0] addr, input logic [31:0] data);
		bus_cycle(1'b1, addr, data);
	endtask

	task automatic wb_read(input logic [31:0] addr);
		bus_cycle(1'b0, addr, 32'd0);
	endtask

	// Read request held for 4 cycles before it is dropped
	task automatic hold_request(input logic [31:0] addr);
		@(posedge clk);
		#2;
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we = 1'b0;
		wb_req.adr = addr;
		repeat (4) @(posedge clk);
		#2;
		wb_req.cyc = 1'b0;
		wb_req.stb = 1'b0;
	endtask

	task automatic set_switches(input io_pkg::sw_t value);
		@(posedge clk);
		#2;
		sw_pins = value;
		repeat (3) @(posedge clk);
	endtask

	// Hold long enough to pass the debouncer
	task automatic hold_buttons(input io_pkg::btn_t value);
		@(posedge clk);
		#2;
		btn_pins = value;
		repeat (HOLD_CYCLES) @(posedge clk);
		exp_btn = value;
	endtask

	task automatic pulse_buttons(input io_pkg::btn_t value, input int len);
		@(posedge clk);
		#2;
		btn_pins = value;
		repeat (len) @(posedge clk);
		#2;
		btn_pins = '0;
	endtask

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	a_reset_state: assert property (@(posedge clk)
		$fell(rst) |-> led == '0 && !wb_rsp.ack)
	else
		report_mismatch("LED register or ack not clear after reset");

	a_ack_after_rise: assert property (@(posedge clk) disable iff (rst)
		$rose(wb_req.stb) && addr_in_window(wb_req.adr) |=> wb_rsp.ack)
	else
		report_mismatch("no ack one cycle after stb rose");

	a_ack_one_cycle: assert property (@(posedge clk) disable iff (rst)
		wb_rsp.ack |=> !wb_rsp.ack)
	else
		report_mismatch("ack held for more than one cycle");

	a_no_ack_outside: assert property (@(posedge clk) disable iff (rst)
		wb_req.cyc && wb_req.stb && !addr_in_window(wb_req.adr) |=> !wb_rsp.ack)
	else
		report_mismatch("ack for an address outside the window");

	a_read_data: assert property (@(posedge clk) disable iff (rst)
		wb_rsp.ack && rd_check |-> wb_rsp.dat == exp_rd)
	else
		report_mismatch($sformatf("read data 0x%08h, expected 0x%08h", wb_rsp.dat, exp_rd));

	a_led_value: assert property (@(posedge clk) disable iff (rst)
		led == exp_led)
	else
		report_mismatch($sformatf("led_o 0x%04h, expected 0x%04h", led, exp_led));

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	initial begin
		logic [31:0] data;
		io_pkg::sw_t sw_value;
		io_pkg::btn_t press;
		clk = 1'b0;
		rst = 1'b1;
		wb_req = '0;
		sw_pins = '0;
		btn_pins = '0;
		exp_led = '0;
		exp_btn = '0;
		timer_v = 32'd0;
		timer_cycle = 0;
		exp_rd = 32'd0;
		rd_check = 1'b0;
		cycle = 0;
		ack_cycle = 0;
		mismatches = 0;
		other_errors = 0;
		void'($urandom(32'h15ffb825));
		repeat (5) @(posedge clk);
		#2;
		rst = 1'b0;

		// LED register with masked upper write bits
		wb_read(LED_ADDR);
		repeat (6) begin
			data = $urandom;
			wb_write(LED_ADDR, data);
			wb_read(LED_ADDR);
		end
		data = 32'hffff_0000 | $urandom;
		wb_write(LED_ADDR, data);
		wb_read(LED_ADDR);

		// Read-only and unmapped offsets
		wb_write(SW_ADDR, $urandom);
		wb_write(HOLE_ADDR, $urandom);
		wb_read(HOLE_ADDR);
		hold_request(STRAY_ADDR);
		// Held request in the window gets an ack every other cycle
		hold_request(LED_ADDR);
		wb_read(LED_ADDR);

		// Switches
		repeat (4) begin
			sw_value = io_pkg::sw_t'($urandom);
			set_switches(sw_value);
			wb_read(SW_ADDR);
		end

		// Buttons pressed then released
		repeat (3) begin
			press = io_pkg::btn_t'($urandom_range(31, 1));
			hold_buttons(press);
			wb_read(BTN_ADDR);
			hold_buttons('0);
			wb_read(BTN_ADDR);
		end
		// Short glitch that reads never see
		fork
			pulse_buttons(5'b11111, GLITCH_CYCLES);
			repeat (6) wb_read(BTN_ADDR);
		join
		repeat (4) wb_read(BTN_ADDR);

		// Timer over several milliseconds
		data = $urandom;
		wb_write(TIMER_ADDR, data);
		repeat (40) @(posedge clk);
		wb_read(TIMER_ADDR);
		repeat (80) @(posedge clk);
		wb_read(TIMER_ADDR);
		repeat (150) @(posedge clk);
		wb_read(TIMER_ADDR);
		// Wrap through zero
		wb_write(TIMER_ADDR, 32'hffff_ffff);
		repeat (60) @(posedge clk);
		wb_read(TIMER_ADDR);

		repeat (2) @(posedge clk);
		$display("Errors: %0d mismatches, %0d bus failures", mismatches, other_errors);
		if (mismatches == 0 && other_errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

//--- verilog/io_system.sv
`timescale 1ns/1ps

// Top of the I/O block
// Board pins in, bus slave out
module io_system (
	input logic clk,
	input logic rst,
	input io_pkg::wb_req_t wb_req_i,
	output io_pkg::wb_rsp_t wb_rsp_o,
	input io_pkg::sw_t sw_i,
	input io_pkg::btn_t btn_i,
	output io_pkg::sw_t led_o
);

	// Switches and buttons inside the clock domain
	io_pkg::sw_t sw_sync;
	io_pkg::btn_t btn_sync;
	io_pkg::btn_t btn_stable;

	// Timer hookup
	logic [31:0] timer_count;
	logic timer_load;
	logic [31:0] timer_load_value;

	//////////////////////////////////////////////////
	// Input conditioning
	//////////////////////////////////////////////////

	// Switches need no debounce
	input_sync #(.payload_t(io_pkg::sw_t)) sw_sync0 (
		.clk(clk),
		.rst(rst),
		.async_i(sw_i),
		.sync_o(sw_sync)
	);

	input_sync #(.payload_t(io_pkg::btn_t)) btn_sync0 (
		.clk(clk),
		.rst(rst),
		.async_i(btn_i),
		.sync_o(btn_sync)
	);

	debounce btn_deb0 (
		.clk(clk),
		.rst(rst),
		.raw_i(btn_sync),
		.stable_o(btn_stable)
	);

	//////////////////////////////////////////////////
	// Timer and registers
	//////////////////////////////////////////////////

	ms_timer timer0 (
		.clk(clk),
		.rst(rst),
		.load_i(timer_load),
		.load_value_i(timer_load_value),
		.count_o(timer_count)
	);

	io_regs regs0 (
		.clk(clk),
		.rst(rst),
		.wb_req_i(wb_req_i),
		.wb_rsp_o(wb_rsp_o),
		.sw_i(sw_sync),
		.btn_i(btn_stable),
		.timer_count_i(timer_count),
		.timer_load_o(timer_load),
		.timer_load_value_o(timer_load_value),
		.led_o(led_o)
	);

endmodule

//--- verilog/io_regs.sv
`timescale 1ns/1ps

// Wishbone classic slave for the I/O window
// Holds the LED register, drives the timer load, muxes read data
module io_regs (
	input logic clk,
	input logic rst,
	input io_pkg::wb_req_t wb_req_i,
	output io_pkg::wb_rsp_t wb_rsp_o,
	input io_pkg::sw_t sw_i,
	input io_pkg::btn_t btn_i,
	input logic [31:0] timer_count_i,
	output logic timer_load_o,
	output logic [31:0] timer_load_value_o,
	output io_pkg::sw_t led_o
);

	// Word offset inside the window
	typedef logic [io_pkg::IO_ADDR_BITS-1:2] word_t;

	logic in_window;
	logic req;
	word_t word_addr;
	logic led_we;
	logic timer_we;
	logic ack_q;
	logic [31:0] rd_mux;
	logic [31:0] rd_data_q;
	io_pkg::sw_t led_q;

	//////////////////////////////////////////////////
	// Decode
	//////////////////////////////////////////////////

	// Upper address bits must hit the window base
	assign in_window = (wb_req_i.adr[31:io_pkg::IO_ADDR_BITS] ==
		io_pkg::IO_BASE[31:io_pkg::IO_ADDR_BITS]);
	assign word_addr = wb_req_i.adr[io_pkg::IO_ADDR_BITS-1:2];

	// New transfer, blocked in the ack cycle so acks never run back to back
	assign req = wb_req_i.cyc && wb_req_i.stb && in_window && !ack_q;

	// Write strobes, taken at the edge that raises ack
	always_comb begin
		led_we = 1'b0;
		timer_we = 1'b0;
		if (req && wb_req_i.we) begin
			case (word_addr)
				io_pkg::LED_OFFSET[io_pkg::IO_ADDR_BITS-1:2]: led_we = 1'b1;
				io_pkg::TIMER_OFFSET[io_pkg::IO_ADDR_BITS-1:2]: timer_we = 1'b1;
				// Switches, buttons and holes ignore writes
				default: ;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Ack and LED register
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			ack_q <= 1'b0;
			led_q <= '0;
		end else begin
			ack_q <= req;
			// Upper write bits dropped
			if (led_we)
				led_q <= wb_req_i.dat[io_pkg::LED_WIDTH-1:0];
		end
	end

	// Timer loads in the same edge as the ack
	assign timer_load_o = timer_we;
	assign timer_load_value_o = wb_req_i.dat;

	//////////////////////////////////////////////////
	// Read path
	//////////////////////////////////////////////////

	// Sources zero-extended to the bus width
	always_comb begin
		case (word_addr)
			io_pkg::LED_OFFSET[io_pkg::IO_ADDR_BITS-1:2]: rd_mux = 32'(led_q);
			io_pkg::SW_OFFSET[io_pkg::IO_ADDR_BITS-1:2]: rd_mux = 32'(sw_i);
			io_pkg::BTN_OFFSET[io_pkg::IO_ADDR_BITS-1:2]: rd_mux = 32'(btn_i);
			io_pkg::TIMER_OFFSET[io_pkg::IO_ADDR_BITS-1:2]: rd_mux = timer_count_i;
			// Unmapped offsets read zero
			default: rd_mux = 32'd0;
		endcase
	end

	// Sampled with the request, valid alongside ack
	always_ff @(posedge clk) begin
		if (req)
			rd_data_q <= rd_mux;
	end

	assign wb_rsp_o.ack = ack_q;
	assign wb_rsp_o.dat = rd_data_q;
	assign led_o = led_q;

	//////////////////////////////////////////////////
	// Bus checks
	//////////////////////////////////////////////////

	// Single-cycle ack
	a_ack_single: assert property (@(posedge clk) disable iff (rst)
		wb_rsp_o.ack |=> !wb_rsp_o.ack);

	// Ack only answers a live request
	a_ack_after_req: assert property (@(posedge clk) disable iff (rst)
		wb_rsp_o.ack |-> $past(wb_req_i.cyc && wb_req_i.stb));

endmodule

//--- verilog/ms_timer.sv
`timescale 1ns/1ps

// Free-running millisecond counter
// Loadable from the bus, load also restarts the tick phase
module ms_timer (
	input logic clk,
	input logic rst,
	input logic load_i,
	input logic [31:0] load_value_i,
	output logic [31:0] count_o
);

	// Tick counter spans one millisecond
	typedef logic [$clog2(io_pkg::CLOCKS_PER_MS)-1:0] tick_t;

	tick_t tick_q;
	logic [31:0] count_q;
	logic tick_wrap;

	// Last clock of the current millisecond
	assign tick_wrap = (tick_q == tick_t'(io_pkg::CLOCKS_PER_MS - 1));

	//////////////////////////////////////////////////
	// Tick and millisecond count
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			tick_q <= '0;
			count_q <= '0;
		end else if (load_i) begin
			// Load wins over a pending tick
			tick_q <= '0;
			count_q <= load_value_i;
		end else if (tick_wrap) begin
			tick_q <= '0;
			count_q <= count_q + 32'd1;
		end else begin
			tick_q <= tick_q + 1'b1;
		end
	end

	assign count_o = count_q;

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	// No load, so at most one millisecond per clock
	a_count_step: assert property (@(posedge clk) disable iff (rst)
		!load_i |=> (count_o - $past(count_o)) <= 32'd1);

endmodule

//--- verilog/debounce.sv
`timescale 1ns/1ps

// Button debouncer for the whole synchronized vector
// A new value passes once it has held for DEBOUNCE_CYCLES samples
module debounce (
	input logic clk,
	input logic rst,
	input io_pkg::btn_t raw_i,
	output io_pkg::btn_t stable_o
);

	// Counter wide enough to hold DEBOUNCE_CYCLES
	typedef logic [$clog2(io_pkg::DEBOUNCE_CYCLES+1)-1:0] cnt_t;

	io_pkg::btn_t sample_q;
	io_pkg::btn_t stable_q;
	cnt_t cnt_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			sample_q <= '0;
			stable_q <= '0;
			cnt_q <= '0;
		end else begin
			if (raw_i != sample_q) begin
				// Input moved, restart the count with this first sample
				sample_q <= raw_i;
				cnt_q <= cnt_t'(1);
			end else if (cnt_q != cnt_t'(io_pkg::DEBOUNCE_CYCLES)) begin
				cnt_q <= cnt_q + 1'b1;
			end
			// Saturated count means the sample held long enough
			if (cnt_q == cnt_t'(io_pkg::DEBOUNCE_CYCLES))
				stable_q <= sample_q;
		end
	end

	assign stable_o = stable_q;

	// Output may only move right after the counter saturated
	a_change_after_sat: assert property (@(posedge clk) disable iff (rst)
		!$stable(stable_o) |-> $past(cnt_q) == cnt_t'(io_pkg::DEBOUNCE_CYCLES));

endmodule

//--- verilog/input_sync.sv
`timescale 1ns/1ps

// Two-flop synchronizer for board inputs
// Payload type chosen per instance (switches or buttons)
module input_sync #(
	parameter type payload_t = logic
) (
	input logic clk,
	input logic rst,
	input payload_t async_i,
	output payload_t sync_o
);

	// First stage, may go metastable
	payload_t meta_q;
	// Second stage, safe to use in the clock domain
	payload_t sync_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			meta_q <= '0;
			sync_q <= '0;
		end else begin
			meta_q <= async_i;
			sync_q <= meta_q;
		end
	end

	// Output two cycles behind the pin
	assign sync_o = sync_q;

endmodule

//--- verilog/io_pkg.sv
package io_pkg;

	//////////////////////////////////////////////////
	// Address map
	//////////////////////////////////////////////////

	// Base of the 256-byte I/O window
	localparam logic [31:0] IO_BASE = 32'h0000_7f00;
	// Offset bits inside the window
	localparam int IO_ADDR_BITS = 8;

	// Register byte offsets
	localparam logic [7:0] LED_OFFSET = 8'h00;
	localparam logic [7:0] SW_OFFSET = 8'h04;
	localparam logic [7:0] BTN_OFFSET = 8'h24;
	localparam logic [7:0] TIMER_OFFSET = 8'h30;

	// LED register and switch vector width
	localparam int LED_WIDTH = 16;

	//////////////////////////////////////////////////
	// Timing, scaled down for short simulations
	//////////////////////////////////////////////////

	// Clocks per millisecond tick
	localparam int CLOCKS_PER_MS = 50;
	// Stable cycles before a button change is taken
	localparam int DEBOUNCE_CYCLES = 8;

	//////////////////////////////////////////////////
	// Types
	//////////////////////////////////////////////////

	// Wishbone classic request, master to slave
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [31:0] adr;
		logic [31:0] dat;
	} wb_req_t;

	// Wishbone classic response, slave to master
	typedef struct packed {
		logic ack;
		logic [31:0] dat;
	} wb_rsp_t;

	// Buttons, c lands in bit 0 of the read word
	typedef struct packed {
		logic u;
		logic r;
		logic d;
		logic l;
		logic c;
	} btn_t;

	// Switch vector, same width as the LEDs
	typedef logic [LED_WIDTH-1:0] sw_t;

endpackage
